// ==== common/spi_cfg_pkg.sv ====
package spi_cfg_pkg;

	parameter int ADDR_W = 16;
	parameter int DATA_W = 8;
	parameter int FRAME_BITS = ADDR_W + DATA_W; // SCK cycles per frame

	// One queued SPI command, exactly one FIFO word
	typedef struct packed {
		logic              read;
		logic [ADDR_W-1:0] addr; // Top bit carries the read flag
		logic [DATA_W-1:0] data; // Zero for reads
	} spi_cmd_t;

	// Read result returned to the host
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} spi_rsp_t;

	// Host request, address without the read flag
	typedef struct packed {
		logic              read;
		logic              verify; // Read back after the write
		logic [ADDR_W-2:0] addr;
		logic [DATA_W-1:0] data;
	} host_req_t;

endpackage

// ==== verilog/cfg_sequencer.sv ====
module cfg_sequencer
	import spi_cfg_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      req,
	input  host_req_t req_data,
	output logic      busy,
	output logic      overflow,
	input  logic      full,
	output logic      push,
	output spi_cmd_t  cmd
);

	logic     push_r;    // First push of an accepted request
	spi_cmd_t cmd_r;
	logic     pending;   // Verify read still to be queued
	spi_cmd_t pend_cmd;
	logic     accept;
	logic     push_pend;

	// A push in flight is not yet reflected in full, so hold the host off
	assign busy = pending | full | push_r;
	assign accept = req & ~busy;

	// Second push waits one cycle after the first so full is current
	assign push_pend = pending & ~push_r & ~full;
	assign push = push_r | push_pend;
	assign cmd = push_r ? cmd_r : pend_cmd;

	always_ff @(posedge clk) begin
		if (rst) begin
			push_r <= 1'b0;
			pending <= 1'b0;
			overflow <= 1'b0;
		end else begin
			push_r <= accept;
			if (accept && req_data.verify && !req_data.read)
				pending <= 1'b1;
			else if (push_pend)
				pending <= 1'b0;
			if (req && busy)
				overflow <= 1'b1; // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_r.read <= req_data.read;
			cmd_r.addr <= {req_data.read, req_data.addr};
			cmd_r.data <= req_data.read ? '0 : req_data.data;
			pend_cmd.read <= 1'b1; // Readback of the same register
			pend_cmd.addr <= {1'b1, req_data.addr};
			pend_cmd.data <= '0;
		end
	end

endmodule

// ==== verilog/cmd_fifo.sv ====
module cmd_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  FIFO_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t wr_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	payload_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	assign empty = (count == '0);
	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign head = mem[rd_ptr]; // Show-ahead

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
	end

endmodule

// ==== spi_master/spi_master.sv ====
module spi_master
	import spi_cfg_pkg::*;
#(
	parameter int SCK_HALF = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     empty,
	input  spi_cmd_t head,
	output logic     pop,
	output logic     cs_n,
	output logic     sck,
	output logic     sdio_out,
	output logic     sdio_oe,
	input  logic     sdio_in,
	output logic     rsp_valid,
	output spi_rsp_t rsp
);

	localparam int HALF_W = $clog2(SCK_HALF + 1);
	localparam int EDGE_W = $clog2(FRAME_BITS + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,  // Pop cycle, head still holds the command
		ST_FRAME,
		ST_DONE
	} state_t;

	state_t                state;
	logic [HALF_W-1:0]     half_cnt;
	logic [EDGE_W-1:0]     edge_cnt;   // Rising edges so far
	logic                  sck_r;
	logic                  half_end;
	logic                  sck_rise;
	logic                  sck_fall;
	logic                  frame_end;
	logic [FRAME_BITS-1:0] tx_sr;
	logic [DATA_W-1:0]     rx_sr;
	logic                  rd_frame;
	logic [ADDR_W-1:0]     frame_addr;

	assign half_end = (state == ST_FRAME) && (half_cnt == HALF_W'(SCK_HALF - 1));
	assign sck_rise = half_end && !sck_r && (edge_cnt != EDGE_W'(FRAME_BITS));
	assign sck_fall = half_end && sck_r;

	// Trailing low half after the last falling edge closes the frame
	assign frame_end = half_end && !sck_r && (edge_cnt == EDGE_W'(FRAME_BITS));

	assign sck = sck_r;
	assign sdio_out = tx_sr[FRAME_BITS-1]; // MSB first, read flag leads

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			pop <= 1'b0;
			cs_n <= 1'b1;
			sck_r <= 1'b0;
			sdio_oe <= 1'b0;
			half_cnt <= '0;
			edge_cnt <= '0;
			rsp_valid <= 1'b0;
		end else begin
			pop <= 1'b0;
			rsp_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (!empty) begin
						pop <= 1'b1;
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					cs_n <= 1'b0;
					sdio_oe <= 1'b1;
					half_cnt <= '0;
					edge_cnt <= '0;
					state <= ST_FRAME;
				end
				ST_FRAME: begin
					half_cnt <= half_end ? '0 : half_cnt + 1'b1;
					if (sck_rise) begin
						sck_r <= 1'b1;
						edge_cnt <= edge_cnt + 1'b1;
					end
					if (sck_fall) begin
						sck_r <= 1'b0;
						// Device takes the line after the last address bit
						if (rd_frame && edge_cnt == EDGE_W'(ADDR_W))
							sdio_oe <= 1'b0;
					end
					if (frame_end) begin
						cs_n <= 1'b1;
						sdio_oe <= 1'b0;
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					rsp_valid <= rd_frame; // Also the gap before the next pop
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_LOAD) begin
			tx_sr <= {head.addr, head.data};
			rd_frame <= head.read;
			frame_addr <= head.addr;
		end else if (sck_fall) begin
			tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};
		end
		if (sck_rise && edge_cnt >= EDGE_W'(ADDR_W))
			rx_sr <= {rx_sr[DATA_W-2:0], sdio_in}; // Data phase only
		if (frame_end) begin
			rsp.addr <= frame_addr;
			rsp.data <= rx_sr;
		end
	end

endmodule

// ==== verilog/spi_cfg_top.sv ====
module spi_cfg_top
	import spi_cfg_pkg::*;
#(
	parameter int SCK_HALF = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      req,
	input  host_req_t req_data,
	output logic      busy,
	output logic      overflow,
	output logic      cs_n,
	output logic      sck,
	output logic      sdio_out,
	output logic      sdio_oe,
	input  logic      sdio_in,
	output logic      rsp_valid,
	output spi_rsp_t  rsp
);

	logic     push;
	logic     pop;
	logic     full;
	logic     empty;
	spi_cmd_t seq_cmd;
	spi_cmd_t fifo_head;

	cfg_sequencer u_seq (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.req_data (req_data),
		.busy     (busy),
		.overflow (overflow),
		.full     (full),
		.push     (push),
		.cmd      (seq_cmd)
	);

	cmd_fifo #(
		.payload_t  (spi_cmd_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk     (clk),
		.rst     (rst),
		.push    (push),
		.wr_data (seq_cmd),
		.pop     (pop),
		.head    (fifo_head),
		.empty   (empty),
		.full    (full)
	);

	spi_master #(
		.SCK_HALF (SCK_HALF)
	) u_master (
		.clk       (clk),
		.rst       (rst),
		.empty     (empty),
		.head      (fifo_head),
		.pop       (pop),
		.cs_n      (cs_n),
		.sck       (sck),
		.sdio_out  (sdio_out),
		.sdio_oe   (sdio_oe),
		.sdio_in   (sdio_in),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

// ==== tb/spi_dev_model.sv ====
module spi_dev_model (
	input  logic cs_n,
	input  logic sck,
	input  logic sdio_out,
	output logic sdio_in
);

	logic [7:0]  regs [16];
	logic [23:0] shift_in;
	logic [15:0] frame_addr; // Read flag in bit 15
	int          bit_cnt;

	initial begin
		for (int i = 0; i < 16; i++)
			regs[i] = 8'(i) ^ 8'h5A;
		shift_in = '0;
		frame_addr = '0;
		bit_cnt = 0;
		sdio_in = 1'b0;
	end

	// Bits are taken on the rising SCK edge, writes land when chip select rises
	always @(posedge sck or posedge cs_n) begin
		if (cs_n) begin
			if (bit_cnt == 24 && !frame_addr[15])
				regs[frame_addr[3:0]] <= shift_in[7:0];
			bit_cnt <= 0;
		end else begin
			shift_in <= {shift_in[22:0], sdio_out};
			if (bit_cnt == 15)
				frame_addr <= {shift_in[14:0], sdio_out}; // Full address after the 16th bit
			bit_cnt <= bit_cnt + 1;
		end
	end

	// Read data goes out MSB first, one bit per falling edge of the data phase
	always @(negedge sck) begin
		if (!cs_n && frame_addr[15] && bit_cnt >= 16 && bit_cnt < 24)
			sdio_in <= regs[frame_addr[3:0]][23 - bit_cnt];
		else
			sdio_in <= 1'b0;
	end

endmodule

// ==== tb/spi_cfg_checker.sv ====
module spi_cfg_checker (
	input logic clk,
	input logic rst,
	input logic cs_n,
	input logic sck,
	input logic sdio_oe,
	input logic pop
);

	int fail_cnt = 0;

	sck_idle: assert property (@(posedge clk) disable iff (rst) cs_n |-> !sck)
		else begin
			$error("SCK is high while chip select is inactive");
			fail_cnt++;
		end

	// Master releases the data line between frames
	oe_idle: assert property (@(posedge clk) disable iff (rst) cs_n |-> !sdio_oe)
		else begin
			$error("Data line is driven while chip select is inactive");
			fail_cnt++;
		end

	pop_idle: assert property (@(posedge clk) disable iff (rst) !cs_n |-> !pop)
		else begin
			$error("FIFO pop issued during a frame");
			fail_cnt++;
		end

endmodule

bind spi_master spi_cfg_checker u_chk (
	.clk     (clk),
	.rst     (rst),
	.cs_n    (cs_n),
	.sck     (sck),
	.sdio_oe (sdio_oe),
	.pop     (pop)
);

// ==== tb/spi_cfg_tb.sv ====
module spi_cfg_tb
	import spi_cfg_pkg::*;
();

	localparam int SCK_HALF = 4;
	localparam int FIFO_DEPTH = 4;
	localparam int N_RAND = 40;
	localparam int REQ_BUDGET = 16 + 8 + 4 + 2 * (N_RAND + 1) + 16 + 4; // Verify counts twice

	logic      clk;
	logic      rst;
	logic      req;
	host_req_t req_data;
	logic      busy;
	logic      overflow;
	logic      cs_n;
	logic      sck;
	logic      sdio_out;
	logic      sdio_oe;
	logic      sdio_in;
	logic      rsp_valid;
	spi_rsp_t  rsp;

	logic [7:0]  shadow [16]; // Expected device register contents
	spi_rsp_t    exp_q [$];
	logic [31:0] lfsr;
	logic        cs_prev;
	int          errors;
	int          rsp_cnt;
	int          exp_rsp_cnt;
	int          frame_cnt;
	int          exp_frames;
	int          sck_bits;    // SCK rises so far in the current frame
	logic        frame_rd;    // Read flag seen on the first bit

	spi_cfg_top #(
		.SCK_HALF   (SCK_HALF),
		.FIFO_DEPTH (FIFO_DEPTH)
	) UUT (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_data  (req_data),
		.busy      (busy),
		.overflow  (overflow),
		.cs_n      (cs_n),
		.sck       (sck),
		.sdio_out  (sdio_out),
		.sdio_oe   (sdio_oe),
		.sdio_in   (sdio_in),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	spi_dev_model dev (
		.cs_n     (cs_n),
		.sck      (sck),
		.sdio_out (sdio_out),
		.sdio_in  (sdio_in)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic spi_rsp_t expect_read(input logic [14:0] a);
		spi_rsp_t r;
		r.addr = {1'b1, a};
		r.data = shadow[a[3:0]];
		return r;
	endfunction

	task automatic check_bit(input string name, input logic got, input logic want);
		assert (got === want) else begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, want);
		end
	endtask

	// Called and returns 5 units after a rising edge
	task automatic issue_req(input logic rd, input logic vfy, input logic [14:0] a,
		input logic [7:0] d);
		while (busy) begin
			@(posedge clk);
			#5;
		end
		req = 1'b1;
		req_data.read = rd;
		req_data.verify = vfy;
		req_data.addr = a;
		req_data.data = d;
		if (!rd)
			shadow[a[3:0]] = d;
		if (rd || vfy) begin
			exp_q.push_back(expect_read(a));
			exp_rsp_cnt++;
		end
		exp_frames += (!rd && vfy) ? 2 : 1;
		@(posedge clk);
		#5;
		req = 1'b0;
	endtask

	task automatic strobe_dropped(input logic [14:0] a, input logic [7:0] d);
		int n;
		n = 0;
		while (!busy && n < 8) begin
			@(posedge clk);
			#5;
			n++;
		end
		assert (busy) else begin
			errors++;
			$display("Busy did not rise while the FIFO was being filled");
		end
		req = 1'b1;
		req_data.read = 1'b0;
		req_data.verify = 1'b0;
		req_data.addr = a;
		req_data.data = d;
		@(posedge clk);
		#5;
		req = 1'b0;
	endtask

	task automatic drain_responses();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#5;
		end
	endtask

	always @(posedge clk) begin
		cs_prev <= cs_n;
		if (!rst && cs_prev && !cs_n)
			frame_cnt++;
	end

	// Data line owner at each SCK rise
	always @(posedge sck or posedge cs_n) begin
		if (cs_n) begin
			sck_bits = 0;
		end else begin
			if (sck_bits == 0)
				frame_rd = sdio_out;
			check_bit("sdio_oe", sdio_oe, !(frame_rd && sck_bits >= ADDR_W));
			sck_bits++;
		end
	end

	always @(posedge clk) begin
		spi_rsp_t want;
		if (!rst && rsp_valid === 1'b1) begin
			rsp_cnt++;
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("Read response for address %h arrived with none expected", rsp.addr);
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				assert (rsp.addr === want.addr) else begin
					errors++;
					$display("ERR rsp.addr got %h expected %h", rsp.addr, want.addr);
				end
				assert (rsp.data === want.data) else begin
					errors++;
					$display("ERR rsp.data got %h expected %h", rsp.data, want.data);
				end
			end
		end
	end

	initial begin
		repeat (REQ_BUDGET * (26 * 2 * SCK_HALF + 10)) @(posedge clk);
		$display("Timeout: the run did not finish within the cycle budget");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic [1:0]  kind;
		logic [14:0] a;
		int          total;
		rst = 1'b1;
		req = 1'b0;
		req_data = '0;
		lfsr = 32'hf845;
		errors = 0;
		rsp_cnt = 0;
		exp_rsp_cnt = 0;
		frame_cnt = 0;
		exp_frames = 0;
		sck_bits = 0;
		frame_rd = 1'b0;
		for (int i = 0; i < 16; i++)
			shadow[i] = 8'(i) ^ 8'h5A;
		repeat (3) @(posedge clk);
		#5;
		rst = 1'b0;
		@(posedge clk);
		#5;
		check_bit("cs_n", cs_n, 1'b1);
		check_bit("sck", sck, 1'b0);
		check_bit("sdio_oe", sdio_oe, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("overflow", overflow, 1'b0);
		check_bit("rsp_valid", rsp_valid, 1'b0);

		for (int i = 0; i < 16; i++) begin
			a = {3'b101, 4'(i), 4'h0, 4'(i)};
			issue_req(1'b1, 1'b0, a, 8'h00);
		end
		drain_responses();

		for (int i = 8; i < 12; i++)
			issue_req(1'b0, 1'b0, 15'(i), 8'(i * 37));
		for (int i = 11; i >= 8; i--)
			issue_req(1'b1, 1'b0, 15'(i), 8'h00);
		drain_responses();

		issue_req(1'b0, 1'b1, 15'h7A0C, 8'hC3);
		issue_req(1'b0, 1'b1, 15'h000D, 8'h3C);
		drain_responses();

		for (int n = 0; n < N_RAND; n++) begin
			kind = 2'(take_bits(2));
			a = 15'(take_bits(15));
			issue_req(kind == 2'd0 || kind == 2'd3, kind == 2'd2, a, 8'(take_bits(8)));
		end
		issue_req(1'b1, 1'b0, 15'(take_bits(15)), 8'h00); // Closing read marks the drain point
		drain_responses();

		check_bit("overflow", overflow, 1'b0);
		for (int i = 0; i < 5; i++)
			issue_req(1'b0, 1'b0, 15'(i), 8'(8'hA0 + i));
		for (int i = 5; i < 8; i++)
			strobe_dropped(15'(i), 8'hEE);
		check_bit("overflow", overflow, 1'b1);
		for (int i = 0; i < 8; i++)
			issue_req(1'b1, 1'b0, 15'(i), 8'h00);
		drain_responses();

		repeat (2 * 26 * 2 * SCK_HALF) @(posedge clk); // Room for any stray frame
		#5;
		check_bit("overflow", overflow, 1'b1);
		assert (rsp_cnt == exp_rsp_cnt) else begin
			errors++;
			$display("ERR rsp_valid count got %h expected %h", rsp_cnt, exp_rsp_cnt);
		end
		assert (frame_cnt == exp_frames) else begin
			errors++;
			$display("ERR cs_n frame count got %h expected %h", frame_cnt, exp_frames);
		end

		total = errors + UUT.u_master.u_chk.fail_cnt;
		$display("Errors %0d, checker failures %0d, responses %0d, frames %0d",
			errors, UUT.u_master.u_chk.fail_cnt, rsp_cnt, frame_cnt);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== build.f ====
common/spi_cfg_pkg.sv
verilog/cfg_sequencer.sv
verilog/cmd_fifo.sv
spi_master/spi_master.sv
verilog/spi_cfg_top.sv
tb/spi_dev_model.sv
tb/spi_cfg_checker.sv
tb/spi_cfg_tb.sv
